// File: design/wc_params.svh
// ==========================================================
// twin-CPU arcade memory system parameters
// bus widths, DIP switch width and bank sizes shared by the
// bus package and the RTL blocks
// ==========================================================

`ifndef WC_PARAMS_SVH
`define WC_PARAMS_SVH

// address width inside one CPU region
`define WC_AW 11

// CPU and video data width
`define WC_DW 8

// DIP switch bank width
`define WC_DIPW 22

// address width of one RAM bank
`define WC_RAM_AW 11

// words per RAM bank
`define WC_RAM_DEPTH (1 << `WC_RAM_AW)

`endif

// File: design/wc_bus_pkg.sv
// ==========================================================
// CPU bus types
// request and response structs of the wait-state handshake
// and the pre-decoded memory region codes
// ==========================================================

`default_nettype none

`include "wc_params.svh"

package wc_bus_pkg;

    // regions as seen by the CPUs (c8, d0, d8, e0, e8 pages)
    // codes 0..3 double as RAM bank index
    typedef enum logic [2:0] {
        rgn_fix  = 3'd0,
        rgn_vram = 3'd1,
        rgn_pal  = 3'd2,
        rgn_work = 3'd3,
        rgn_ctrl = 3'd4
    } region_e;

    typedef struct packed {
        logic                cs;
        logic                we;
        region_e             region;
        logic [`WC_AW-1:0]   addr;
        logic [`WC_DW-1:0]   wdata;
    } cpu_req_t;

    // ready acts as the inverse of the CPU wait line
    typedef struct packed {
        logic                ready;
        logic [`WC_DW-1:0]   rdata;
    } cpu_rsp_t;

endpackage

`default_nettype wire

// File: design/wc_cfg_pkg.sv
// ==========================================================
// board configuration types
// scroll position, board control bits and ROM header flags
// ==========================================================

`default_nettype none

package wc_cfg_pkg;

    // background scroll, x spans 9 bits
    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
    } scroll_t;

    // written from the low nibble of the control byte
    typedef struct packed {
        logic hflip;
        logic vflip;
        logic mute_n;
        logic srst_n;
    } board_ctrl_t;

    // flags from the ROM header byte
    typedef struct packed {
        logic bootleg;
        logic nodipsw1;
    } hdr_cfg_t;

endpackage

`default_nettype wire

// File: design/wc_ram.sv
// ==========================================================
// shared byte RAM bank
// CPU read/write port plus a read-only video port, both
// with registered read data
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "wc_params.svh"

module wc_ram (
    input  wire logic                  clk,
    input  wire logic                  we,
    input  wire logic [`WC_RAM_AW-1:0] cpu_addr,
    input  wire logic [`WC_DW-1:0]     cpu_wdata,
    output      logic [`WC_DW-1:0]     cpu_rdata,
    input  wire logic [`WC_RAM_AW-1:0] vid_addr,
    output      logic [`WC_DW-1:0]     vid_rdata
);

    logic [`WC_DW-1:0] mem [`WC_RAM_DEPTH];

    // cpu side, read returns old data on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        cpu_rdata <= mem[cpu_addr];
    end

    always_ff @(posedge clk) begin
        vid_rdata <= mem[vid_addr];
    end

endmodule

`default_nettype wire

// File: design/wc_latch.sv
// ==========================================================
// loadable register with update strobe
// keeps the last loaded value and flags each load with a
// one-cycle pulse, payload type set per instance
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

module wc_latch #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic load,
    input  payload_t  din,
    output payload_t  q,
    output logic      strobe
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q      <= '0;
            strobe <= 1'b0;
        end else begin
            strobe <= load;
            if (load) begin
                q <= din;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/wc_shared.sv
// ==========================================================
// shared memory controller
// round-robin arbitration of main and sub CPU, bank decode,
// control page registers and video read port
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "wc_params.svh"

module wc_shared (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wc_bus_pkg::cpu_req_t       main_req,
    output wc_bus_pkg::cpu_rsp_t       main_rsp,
    input  wc_bus_pkg::cpu_req_t       sub_req,
    output wc_bus_pkg::cpu_rsp_t       sub_rsp,
    input  wc_bus_pkg::region_e        video_region,
    input  wire logic [`WC_RAM_AW-1:0] video_addr,
    output      logic [`WC_DW-1:0]     video_data,
    output      logic [`WC_DW-1:0]     snd_cmd,
    output      logic                  snd_set,
    output wc_cfg_pkg::scroll_t        scroll,
    output wc_cfg_pkg::board_ctrl_t    board_ctrl
);

    localparam int NBANKS = 4;

    logic main_rdy_q;
    logic sub_rdy_q;
    logic main_elig;
    logic sub_elig;
    logic gnt_main;
    logic gnt_sub;
    logic gnt_any;
    logic prio_sub;
    logic ctrl_we;

    wc_bus_pkg::cpu_req_t    gnt_req;
    wc_bus_pkg::region_e     rd_region_q;
    wc_bus_pkg::region_e     vid_region_q;
    wc_cfg_pkg::scroll_t     scroll_next;
    wc_cfg_pkg::board_ctrl_t board_ctrl_q;

    logic [`WC_DW-1:0] bank_rdata [NBANKS];
    logic [`WC_DW-1:0] vid_rdata  [NBANKS];
    logic [`WC_DW-1:0] rd_data;

    // a cpu whose ready is out this cycle must not be served again
    assign main_elig = main_req.cs & ~main_rdy_q;
    assign sub_elig  = sub_req.cs & ~sub_rdy_q;

    // prio_sub flips on each conflict, main wins the first one
    assign gnt_main = main_elig & (~sub_elig | ~prio_sub);
    assign gnt_sub  = sub_elig & (~main_elig | prio_sub);
    assign gnt_any  = gnt_main | gnt_sub;
    assign gnt_req  = gnt_sub ? sub_req : main_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_rdy_q <= 1'b0;
            sub_rdy_q  <= 1'b0;
            prio_sub   <= 1'b0;
        end else begin
            main_rdy_q <= gnt_main;
            sub_rdy_q  <= gnt_sub;
            if (main_elig && sub_elig) begin
                prio_sub <= ~prio_sub;
            end
        end
    end

    // region of the access being answered next cycle
    always_ff @(posedge clk) begin
        if (gnt_any) begin
            rd_region_q <= gnt_req.region;
        end
        vid_region_q <= video_region;
    end

    for (genvar i = 0; i < NBANKS; i++) begin : g_bank
        wc_ram u_ram (
            .clk       (clk),
            .we        (gnt_any && gnt_req.we && gnt_req.region == wc_bus_pkg::region_e'(i)),
            .cpu_addr  (gnt_req.addr[`WC_RAM_AW-1:0]),
            .cpu_wdata (gnt_req.wdata),
            .cpu_rdata (bank_rdata[i]),
            .vid_addr  (video_addr),
            .vid_rdata (vid_rdata[i])
        );
    end

    // control page reads back as zero
    assign rd_data = (rd_region_q == wc_bus_pkg::rgn_ctrl) ? '0 :
                     bank_rdata[rd_region_q[1:0]];

    assign main_rsp = '{ready: main_rdy_q, rdata: rd_data};
    assign sub_rsp  = '{ready: sub_rdy_q, rdata: rd_data};

    // video only sees fix, vram and palette
    always_comb begin
        case (vid_region_q)
            wc_bus_pkg::rgn_fix,
            wc_bus_pkg::rgn_vram,
            wc_bus_pkg::rgn_pal: video_data = vid_rdata[vid_region_q[1:0]];
            default:             video_data = '0;
        endcase
    end

    // only the main cpu owns the control page
    assign ctrl_we = gnt_main && gnt_req.we && gnt_req.region == wc_bus_pkg::rgn_ctrl;

    always_comb begin
        scroll_next = scroll;
        case (gnt_req.addr)
            `WC_AW'd1: scroll_next.x[7:0] = gnt_req.wdata;
            `WC_AW'd2: scroll_next.x[8]   = gnt_req.wdata[0];
            `WC_AW'd3: scroll_next.y      = gnt_req.wdata;
            default:   scroll_next        = scroll;
        endcase
    end

    wc_latch #(
        .payload_t (logic [`WC_DW-1:0])
    ) u_snd (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (ctrl_we && gnt_req.addr == `WC_AW'd0),
        .din    (gnt_req.wdata),
        .q      (snd_cmd),
        .strobe (snd_set)
    );

    wc_latch #(
        .payload_t (wc_cfg_pkg::scroll_t)
    ) u_scroll (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (ctrl_we && gnt_req.addr >= `WC_AW'd1 && gnt_req.addr <= `WC_AW'd3),
        .din    (scroll_next),
        .q      (scroll),
        .strobe ()
    );

    // flip, mute and sub reset bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            board_ctrl_q <= '0;
        end else if (ctrl_we && gnt_req.addr == `WC_AW'd4) begin
            board_ctrl_q <= wc_cfg_pkg::board_ctrl_t'(gnt_req.wdata[3:0]);
        end
    end

    assign board_ctrl = board_ctrl_q;

endmodule

`default_nettype wire

// File: design/wc_cfg.sv
// ==========================================================
// ROM header loader
// latches bootleg and no-DIP1 flags from the header byte and
// remaps the DIP switches for sets without DIP bank 1
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "wc_params.svh"

module wc_cfg (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                prog_we,
    input  wire logic [`WC_AW-1:0]   prog_addr,
    input  wire logic [`WC_DW-1:0]   prog_data,
    input  wire logic                header,
    input  wire logic [`WC_DIPW-1:0] dipsw,
    output wc_cfg_pkg::hdr_cfg_t     hdr,
    output      logic [`WC_DIPW-1:0] dipsw_adj
);

    // header byte, bit 0 bootleg, bit 1 no dip bank 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr <= '0;
        end else if (prog_we && header && prog_addr == '0) begin
            hdr.bootleg  <= prog_data[0];
            hdr.nodipsw1 <= prog_data[1];
        end
    end

    // missing bank 1 means the switches sit four bits higher
    always_ff @(posedge clk) begin
        dipsw_adj <= hdr.nodipsw1 ? (dipsw << 4) : dipsw;
    end

endmodule

`default_nettype wire

// File: design/wc_core.sv
// ==========================================================
// twin-CPU memory system top
// shared memory controller next to the ROM header loader
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "wc_params.svh"

module wc_core (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // cpu buses
    input  wc_bus_pkg::cpu_req_t       main_req,
    output wc_bus_pkg::cpu_rsp_t       main_rsp,
    input  wc_bus_pkg::cpu_req_t       sub_req,
    output wc_bus_pkg::cpu_rsp_t       sub_rsp,
    // video read port
    input  wc_bus_pkg::region_e        video_region,
    input  wire logic [`WC_RAM_AW-1:0] video_addr,
    output      logic [`WC_DW-1:0]     video_data,
    // sound and board control
    output      logic [`WC_DW-1:0]     snd_cmd,
    output      logic                  snd_set,
    output wc_cfg_pkg::scroll_t        scroll,
    output wc_cfg_pkg::board_ctrl_t    board_ctrl,
    // rom loader
    input  wire logic                  prog_we,
    input  wire logic [`WC_AW-1:0]     prog_addr,
    input  wire logic [`WC_DW-1:0]     prog_data,
    input  wire logic                  header,
    input  wire logic [`WC_DIPW-1:0]   dipsw,
    output wc_cfg_pkg::hdr_cfg_t       hdr,
    output      logic [`WC_DIPW-1:0]   dipsw_adj
);

    wc_shared u_shared (
        .clk          (clk),
        .rst_n        (rst_n),
        .main_req     (main_req),
        .main_rsp     (main_rsp),
        .sub_req      (sub_req),
        .sub_rsp      (sub_rsp),
        .video_region (video_region),
        .video_addr   (video_addr),
        .video_data   (video_data),
        .snd_cmd      (snd_cmd),
        .snd_set      (snd_set),
        .scroll       (scroll),
        .board_ctrl   (board_ctrl)
    );

    wc_cfg u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .header    (header),
        .dipsw     (dipsw),
        .hdr       (hdr),
        .dipsw_adj (dipsw_adj)
    );

endmodule

`default_nettype wire

// File: tests/tb_wc_core.sv
// ==========================================================
// testbench for the twin-CPU memory system
// drives both CPU buses, the video port and the ROM loader
// and checks them against a reference memory model
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "wc_params.svh"

module tb_wc_core;

    // roughly 300 cycles of traffic, limit leaves a wide margin
    localparam int MAX_CYCLES = 2000;
    localparam int NWR = 16;

    logic                    clk;
    logic                    rst_n;
    wc_bus_pkg::cpu_req_t    main_req;
    wc_bus_pkg::cpu_rsp_t    main_rsp;
    wc_bus_pkg::cpu_req_t    sub_req;
    wc_bus_pkg::cpu_rsp_t    sub_rsp;
    wc_bus_pkg::region_e     video_region;
    logic [`WC_RAM_AW-1:0]   video_addr;
    logic [`WC_DW-1:0]       video_data;
    logic [`WC_DW-1:0]       snd_cmd;
    logic                    snd_set;
    wc_cfg_pkg::scroll_t     scroll;
    wc_cfg_pkg::board_ctrl_t board_ctrl;
    logic                    prog_we;
    logic [`WC_AW-1:0]       prog_addr;
    logic [`WC_DW-1:0]       prog_data;
    logic                    header;
    logic [`WC_DIPW-1:0]     dipsw;
    wc_cfg_pkg::hdr_cfg_t    hdr;
    logic [`WC_DIPW-1:0]     dipsw_adj;

    int cycles = 0;
    int main_issued = 0;
    int sub_issued = 0;
    int main_readys = 0;
    int sub_readys = 0;

    // reference memory, keyed by region and address
    logic [`WC_DW-1:0]   model [int];
    wc_bus_pkg::region_e t_rgn [NWR];
    logic [`WC_AW-1:0]   t_addr [NWR];

    wc_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run();
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            fail_run();
        end
    endtask

    function automatic int model_key(input wc_bus_pkg::region_e rgn,
                                     input logic [`WC_AW-1:0] addr);
        return int'(rgn) * 4096 + int'(addr);
    endfunction

    // boards without DIP bank 1 see the switches four bits up
    function automatic logic [`WC_DIPW-1:0] expected_dips(input logic nodip,
                                                         input logic [`WC_DIPW-1:0] sw);
        return nodip ? sw << 4 : sw;
    endfunction

    // one request held until ready, latency counted in cycles
    task automatic bus_access(input bit from_sub, input bit we, input wc_bus_pkg::region_e rgn,
                              input logic [`WC_AW-1:0] addr, input logic [`WC_DW-1:0] wdata,
                              output logic [`WC_DW-1:0] rdata, output int lat);
        wc_bus_pkg::cpu_req_t req;
        wc_bus_pkg::cpu_rsp_t rsp;
        req.cs     = 1'b1;
        req.we     = we;
        req.region = rgn;
        req.addr   = addr;
        req.wdata  = wdata;
        @(posedge clk);
        if (from_sub) begin
            sub_req <= req;
            sub_issued++;
        end else begin
            main_req <= req;
            main_issued++;
        end
        lat = 0;
        // first edge closes the cycle in which cs rose
        @(posedge clk);
        rsp = from_sub ? sub_rsp : main_rsp;
        while (!rsp.ready) begin
            @(posedge clk);
            lat++;
            rsp = from_sub ? sub_rsp : main_rsp;
        end
        rdata = rsp.rdata;
        if (from_sub) begin
            sub_req <= '0;
        end else begin
            main_req <= '0;
        end
    endtask

    task automatic video_read(input wc_bus_pkg::region_e rgn, input logic [`WC_RAM_AW-1:0] addr,
                              output logic [`WC_DW-1:0] data);
        @(posedge clk);
        video_region <= rgn;
        video_addr   <= addr;
        repeat (2) @(posedge clk);
        data = video_data;
    endtask

    // header byte write, flags visible once it returns
    task automatic load_header(input logic [`WC_DW-1:0] flags);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= '0;
        prog_data <= flags;
        header    <= 1'b1;
        @(posedge clk);
        prog_we <= 1'b0;
        header  <= 1'b0;
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && main_rsp.ready) main_readys <= main_readys + 1;
        if (rst_n && sub_rsp.ready) sub_readys <= sub_readys + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

    // ready and snd_set are single-cycle pulses
    assert property (@(posedge clk) disable iff (!rst_n) main_rsp.ready |=> !main_rsp.ready)
        else begin
            $display("main ready stayed high for more than one cycle");
            fail_run();
        end
    assert property (@(posedge clk) disable iff (!rst_n) sub_rsp.ready |=> !sub_rsp.ready)
        else begin
            $display("sub ready stayed high for more than one cycle");
            fail_run();
        end
    assert property (@(posedge clk) disable iff (!rst_n) snd_set |=> !snd_set)
        else begin
            $display("snd_set stayed high for more than one cycle");
            fail_run();
        end

    initial begin : stimulus
        logic [`WC_DW-1:0]   d;
        logic [`WC_DW-1:0]   rd;
        logic [`WC_DW-1:0]   rd_m;
        logic [`WC_DW-1:0]   rd_s;
        logic [`WC_DW-1:0]   snd_exp;
        logic [`WC_DIPW-1:0] old_sw;
        int                  lat;
        int                  lat_m;
        int                  lat_s;
        void'($urandom(32'h4bd2_6d7f));
        rst_n        <= 1'b0;
        main_req     <= '0;
        sub_req      <= '0;
        video_region <= wc_bus_pkg::rgn_fix;
        video_addr   <= '0;
        prog_we      <= 1'b0;
        prog_addr    <= '0;
        prog_data    <= '0;
        header       <= 1'b0;
        dipsw        <= `WC_DIPW'($urandom);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // idle outputs out of reset
        check_value("main_rsp.ready", 0, 32'(main_rsp.ready));
        check_value("sub_rsp.ready", 0, 32'(sub_rsp.ready));
        check_value("snd_set", 0, 32'(snd_set));
        check_value("scroll", 0, 32'(scroll));
        check_value("board_ctrl", 0, 32'(board_ctrl));
        check_value("hdr", 0, 32'(hdr));
        check_value("dipsw_adj", 32'(dipsw), 32'(dipsw_adj));

        // main fills every RAM region, then reads it back
        for (int i = 0; i < NWR; i++) begin
            t_rgn[i]  = wc_bus_pkg::region_e'(i % 4);
            t_addr[i] = `WC_AW'($urandom);
            d = `WC_DW'($urandom);
            bus_access(1'b0, 1'b1, t_rgn[i], t_addr[i], d, rd, lat);
            model[model_key(t_rgn[i], t_addr[i])] = d;
            check_value("main write latency", 1, lat);
        end
        for (int i = 0; i < NWR; i++) begin
            bus_access(1'b0, 1'b0, t_rgn[i], t_addr[i], '0, rd, lat);
            check_value("main_rsp.rdata", 32'(model[model_key(t_rgn[i], t_addr[i])]), 32'(rd));
            check_value("main read latency", 1, lat);
        end

        // sub sees main's work RAM, video sees fix, vram and palette
        for (int i = 3; i < NWR; i += 4) begin
            bus_access(1'b1, 1'b0, t_rgn[i], t_addr[i], '0, rd, lat);
            check_value("sub_rsp.rdata", 32'(model[model_key(t_rgn[i], t_addr[i])]), 32'(rd));
        end
        for (int i = 0; i < NWR; i++) begin
            if (t_rgn[i] != wc_bus_pkg::rgn_work) begin
                video_read(t_rgn[i], t_addr[i], rd);
                check_value("video_data", 32'(model[model_key(t_rgn[i], t_addr[i])]), 32'(rd));
            end
        end

        // two conflicts in a row, winner alternates
        for (int n = 0; n < 2; n++) begin
            fork
                bus_access(1'b0, 1'b0, t_rgn[3], t_addr[3], '0, rd_m, lat_m);
                bus_access(1'b1, 1'b0, t_rgn[7], t_addr[7], '0, rd_s, lat_s);
            join
            check_value("main_rsp.rdata", 32'(model[model_key(t_rgn[3], t_addr[3])]), 32'(rd_m));
            check_value("sub_rsp.rdata", 32'(model[model_key(t_rgn[7], t_addr[7])]), 32'(rd_s));
            check_value("main conflict latency", (n == 0) ? 1 : 2, lat_m);
            check_value("sub conflict latency", (n == 0) ? 2 : 1, lat_s);
        end

        // sound command, then sub writes to the control page
        snd_exp = `WC_DW'($urandom);
        bus_access(1'b0, 1'b1, wc_bus_pkg::rgn_ctrl, `WC_AW'd0, snd_exp, rd, lat);
        check_value("snd_set", 1, 32'(snd_set));
        check_value("snd_cmd", 32'(snd_exp), 32'(snd_cmd));
        bus_access(1'b0, 1'b0, wc_bus_pkg::rgn_ctrl, `WC_AW'd0, '0, rd, lat);
        check_value("main_rsp.rdata", 0, 32'(rd));
        for (int off = 0; off < 5; off++) begin
            bus_access(1'b1, 1'b1, wc_bus_pkg::rgn_ctrl, `WC_AW'(off), `WC_DW'($urandom), rd, lat);
            check_value("snd_set", 0, 32'(snd_set));
            check_value("snd_cmd", 32'(snd_exp), 32'(snd_cmd));
            check_value("scroll", 0, 32'(scroll));
            check_value("board_ctrl", 0, 32'(board_ctrl));
        end

        // scroll bytes and board control from main
        d = `WC_DW'($urandom);
        bus_access(1'b0, 1'b1, wc_bus_pkg::rgn_ctrl, `WC_AW'd1, d, rd, lat);
        check_value("scroll.x", 32'(d), 32'(scroll.x));
        bus_access(1'b0, 1'b1, wc_bus_pkg::rgn_ctrl, `WC_AW'd2, 8'h01, rd, lat);
        check_value("scroll.x", 32'({1'b1, d}), 32'(scroll.x));
        d = `WC_DW'($urandom);
        bus_access(1'b0, 1'b1, wc_bus_pkg::rgn_ctrl, `WC_AW'd3, d, rd, lat);
        check_value("scroll.y", 32'(d), 32'(scroll.y));
        d = `WC_DW'($urandom);
        for (int n = 0; n < 2; n++) begin
            // second pass flips every control bit
            d = d ^ 8'h0f;
            bus_access(1'b0, 1'b1, wc_bus_pkg::rgn_ctrl, `WC_AW'd4, d, rd, lat);
            check_value("board_ctrl.hflip", 32'(d[3]), 32'(board_ctrl.hflip));
            check_value("board_ctrl.vflip", 32'(d[2]), 32'(board_ctrl.vflip));
            check_value("board_ctrl.mute_n", 32'(d[1]), 32'(board_ctrl.mute_n));
            check_value("board_ctrl.srst_n", 32'(d[0]), 32'(board_ctrl.srst_n));
        end

        // header flags and DIP switch remap
        load_header(8'h03);
        check_value("hdr.bootleg", 1, 32'(hdr.bootleg));
        check_value("hdr.nodipsw1", 1, 32'(hdr.nodipsw1));
        @(posedge clk);
        check_value("dipsw_adj", 32'(expected_dips(1'b1, dipsw)), 32'(dipsw_adj));
        old_sw = dipsw;
        dipsw <= `WC_DIPW'($urandom);
        @(posedge clk);
        check_value("dipsw_adj", 32'(expected_dips(1'b1, old_sw)), 32'(dipsw_adj));
        @(posedge clk);
        check_value("dipsw_adj", 32'(expected_dips(1'b1, dipsw)), 32'(dipsw_adj));
        load_header(8'h01);
        check_value("hdr.nodipsw1", 0, 32'(hdr.nodipsw1));
        @(posedge clk);
        check_value("dipsw_adj", 32'(dipsw), 32'(dipsw_adj));

        repeat (2) @(posedge clk);
        check_value("main ready pulses", main_issued, main_readys);
        check_value("sub ready pulses", sub_issued, sub_readys);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/wc_bus_pkg.sv
design/wc_cfg_pkg.sv
design/wc_ram.sv
design/wc_latch.sv
design/wc_shared.sv
design/wc_cfg.sv
design/wc_core.sv
tests/tb_wc_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_wc_core
FILELIST  ?= filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
